// ==== logic/timetag_params.svh ====
`ifndef TIMETAG_PARAMS_SVH
`define TIMETAG_PARAMS_SVH

// ==================================================
// Detector side
// ==================================================
`define TT_CHANNELS 4          // Strobe inputs
`define TT_TS_BITS 24          // Free-running timer width

// Record queues
`define TT_FIFO_DEPTH 16

// ==================================================
// Host command framing
// ==================================================
`define TT_SYNC_BYTE 8'hAA
`define TT_ADDR_ENABLE 8'h01   // Channel enable mask
`define TT_ADDR_POLARITY 8'h02 // Edge polarity mask

`endif

// ==== logic/timetag_pkg.sv ====
`include "timetag_params.svh"

package timetag_pkg;

	// Configuration written by the host
	typedef struct packed {
		logic [`TT_CHANNELS-1:0] enable;   // 1 enables the channel
		logic [`TT_CHANNELS-1:0] polarity; // 1 selects the falling edge
	} cfg_t;

	// ==================================================
	// Records queued for the output bus
	// ==================================================

	// One record per cycle with at least one hit
	typedef struct packed {
		logic [`TT_CHANNELS-1:0] hit;      // Channels that fired together
		logic                    overflow; // Records were lost before this one
		logic [`TT_TS_BITS-1:0]  ts;       // Timer in the edge-detect cycle
	} tag_rec_t;

	// Echo of one complete command frame
	typedef struct packed {
		logic       err;  // Unknown address
		logic [7:0] addr;
		logic [7:0] data;
	} reply_rec_t;

endpackage

// ==== logic/rec_fifo_if.sv ====
interface rec_fifo_if #(
	parameter type payload_t = logic
) ();

	// Write side
	logic     push;
	payload_t wdata;
	logic     full;

	// Read side, rdata is the head entry while not empty
	logic     pop;
	payload_t rdata;
	logic     empty;

	modport producer (output push, output wdata, input full);

	modport consumer (output pop, input rdata, input empty);

	modport fifo (
		input  push,
		input  wdata,
		input  pop,
		output full,
		output rdata,
		output empty
	);

endinterface

// ==== logic/cmd_decoder.sv ====
`include "timetag_params.svh"

module cmd_decoder (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [7:0]         cmd_data,
	input  logic               cmd_wr,
	output timetag_pkg::cfg_t  cfg,
	rec_fifo_if.producer       reply
);

	// Frame is sync, address, data
	typedef enum logic [1:0] {
		S_HUNT,
		S_ADDR,
		S_DATA
	} state_t;

	state_t                  state;
	logic [7:0]              addr_q;     // Address byte of the current frame
	logic                    addr_known;
	logic                    reply_pend; // Reply waiting for a free slot
	timetag_pkg::reply_rec_t reply_rec;

	assign addr_known = (addr_q == `TT_ADDR_ENABLE) || (addr_q == `TT_ADDR_POLARITY);

	// ==================================================
	// Frame parser and configuration registers
	// ==================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= S_HUNT;
			cfg        <= '0;
			reply_pend <= 1'b0;
		end else begin
			if (reply.push)
				reply_pend <= 1'b0;
			if (cmd_wr) begin
				case (state)
					S_HUNT: begin
						if (cmd_data == `TT_SYNC_BYTE) // Anything else is garbage
							state <= S_ADDR;
					end
					S_ADDR: begin
						state <= S_DATA;
					end
					S_DATA: begin
						state      <= S_HUNT;
						reply_pend <= 1'b1;
						if (addr_q == `TT_ADDR_ENABLE)
							cfg.enable <= cmd_data[`TT_CHANNELS-1:0];
						if (addr_q == `TT_ADDR_POLARITY)
							cfg.polarity <= cmd_data[`TT_CHANNELS-1:0];
					end
					default: begin
						state <= S_HUNT;
					end
				endcase
			end
		end
	end

	// Address and reply payload
	always_ff @(posedge clk) begin
		if (cmd_wr && state == S_ADDR)
			addr_q <= cmd_data;
		if (cmd_wr && state == S_DATA) begin
			reply_rec.err  <= !addr_known;
			reply_rec.addr <= addr_q;
			reply_rec.data <= cmd_data;
		end
	end

	// Host pacing keeps the queue from filling, hold the reply if it does
	assign reply.push  = reply_pend && !reply.full;
	assign reply.wdata = reply_rec;

endmodule

// ==== logic/strobe_tagger.sv ====
`include "timetag_params.svh"

module strobe_tagger (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`TT_CHANNELS-1:0] strobe_in,
	input  timetag_pkg::cfg_t       cfg,
	rec_fifo_if.producer            tags
);

	logic [`TT_TS_BITS-1:0]  timer;

	// Synchronizer and edge register
	logic [`TT_CHANNELS-1:0] sync1;
	logic [`TT_CHANNELS-1:0] sync2;
	logic [`TT_CHANNELS-1:0] prev;
	logic [`TT_CHANNELS-1:0] edges;
	logic [`TT_CHANNELS-1:0] hits;

	// Pipeline toward the push
	logic [`TT_CHANNELS-1:0] det_hit; // Stage 1, mask from the edge-detect cycle
	logic [`TT_TS_BITS-1:0]  det_ts;
	logic                    rec_valid; // Stage 2, record ready to push
	logic [`TT_CHANNELS-1:0] rec_hit;
	logic [`TT_TS_BITS-1:0]  rec_ts;
	logic                    ovf_sticky; // Set when a record is dropped

	// Changed and now at the selected level
	assign edges = (sync2 ^ prev) & (sync2 ^ cfg.polarity);
	assign hits  = edges & cfg.enable;

	// ==================================================
	// Timer, synchronizers, pipeline control
	// ==================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timer      <= '0;
			sync1      <= '0;
			sync2      <= '0;
			prev       <= '0;
			det_hit    <= '0;
			rec_valid  <= 1'b0;
			ovf_sticky <= 1'b0;
		end else begin
			timer     <= timer + 1'b1; // Wraps at 2^24
			sync1     <= strobe_in;
			sync2     <= sync1;
			prev      <= sync2;
			det_hit   <= hits;
			rec_valid <= |det_hit;
			if (tags.push)
				ovf_sticky <= 1'b0;
			else if (rec_valid && tags.full)
				ovf_sticky <= 1'b1; // Record lost, flag the next one
		end
	end

	// Timestamp and mask payload
	always_ff @(posedge clk) begin
		det_ts  <= timer;
		rec_hit <= det_hit;
		rec_ts  <= det_ts;
	end

	assign tags.push           = rec_valid && !tags.full;
	assign tags.wdata.hit      = rec_hit;
	assign tags.wdata.overflow = ovf_sticky;
	assign tags.wdata.ts       = rec_ts;

endmodule

// ==== logic/rec_fifo.sv ====
`include "timetag_params.svh"

module rec_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = `TT_FIFO_DEPTH
) (
	input  logic clk,
	input  logic arst_n,
	rec_fifo_if.fifo q
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               do_push;
	logic               do_pop;

	assign do_push = q.push && !q.full;
	assign do_pop  = q.pop && !q.empty;

	assign q.full  = (count == CNT_W'(DEPTH));
	assign q.empty = (count == '0);
	assign q.rdata = mem[rd_ptr]; // Head entry

	// Pointers and occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= q.wdata;
	end

endmodule

// ==== logic/out_arbiter.sv ====
module out_arbiter (
	input  logic        clk,
	input  logic        arst_n,
	rec_fifo_if.consumer tags,
	rec_fifo_if.consumer replies,
	output logic [7:0]  out_data,
	output logic        out_valid,
	input  logic        out_ready
);

	timetag_pkg::tag_rec_t   tag_head;
	timetag_pkg::reply_rec_t reply_head;
	logic                    grant_tag;
	logic                    grant_reply;
	logic                    xfer;
	logic [1:0]              left;     // Bytes after the current one
	logic                    last_tag; // Last record served was a tag
	logic [31:0]             shreg;
	logic [31:0]             load_word;

	assign tag_head   = tags.rdata;
	assign reply_head = replies.rdata;

	// ==================================================
	// Round-robin grant at record boundaries
	// ==================================================
	assign grant_tag   = !tags.empty && (replies.empty || !last_tag);
	assign grant_reply = !replies.empty && (tags.empty || last_tag);

	assign tags.pop    = !out_valid && grant_tag;
	assign replies.pop = !out_valid && grant_reply;

	// Record as it goes on the wire, header first
	always_comb begin
		if (grant_tag)
			load_word = {1'b0, tag_head.overflow, 2'b00, tag_head.hit, tag_head.ts};
		else
			load_word = {1'b1, reply_head.err, 6'b0, reply_head.addr, reply_head.data, 8'h00};
	end

	assign xfer = out_valid && out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			left      <= '0;
			last_tag  <= 1'b0;
		end else if (tags.pop || replies.pop) begin
			out_valid <= 1'b1;
			left      <= tags.pop ? 2'd3 : 2'd2; // 4 or 3 bytes
			last_tag  <= tags.pop;
		end else if (xfer) begin
			if (left == '0)
				out_valid <= 1'b0; // Record done
			else
				left <= left - 1'b1;
		end
	end

	// Shift out MSB first, hold while stalled
	always_ff @(posedge clk) begin
		if (tags.pop || replies.pop)
			shreg <= load_word;
		else if (xfer)
			shreg <= {shreg[23:0], 8'h00};
	end

	assign out_data = shreg[31:24];

endmodule

// ==== logic/timetag_top.sv ====
`include "timetag_params.svh"

module timetag_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [7:0]              cmd_data,
	input  logic                    cmd_wr,
	input  logic [`TT_CHANNELS-1:0] strobe_in,
	output logic [7:0]              out_data,
	output logic                    out_valid,
	input  logic                    out_ready
);

	timetag_pkg::cfg_t cfg; // Decoder to tagger

	// ==================================================
	// Record queues
	// ==================================================
	rec_fifo_if #(.payload_t(timetag_pkg::tag_rec_t))   tag_q ();
	rec_fifo_if #(.payload_t(timetag_pkg::reply_rec_t)) reply_q ();

	rec_fifo #(.payload_t(timetag_pkg::tag_rec_t)) u_tag_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.q      (tag_q.fifo)
	);

	rec_fifo #(.payload_t(timetag_pkg::reply_rec_t)) u_reply_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.q      (reply_q.fifo)
	);

	// Producers
	cmd_decoder u_cmd_decoder (
		.clk      (clk),
		.arst_n   (arst_n),
		.cmd_data (cmd_data),
		.cmd_wr   (cmd_wr),
		.cfg      (cfg),
		.reply    (reply_q.producer)
	);

	strobe_tagger u_strobe_tagger (
		.clk       (clk),
		.arst_n    (arst_n),
		.strobe_in (strobe_in),
		.cfg       (cfg),
		.tags      (tag_q.producer)
	);

	// Shared output byte bus
	out_arbiter u_out_arbiter (
		.clk       (clk),
		.arst_n    (arst_n),
		.tags      (tag_q.consumer),
		.replies   (reply_q.consumer),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

// ==== dv/timetag_props.sv ====
module timetag_props (
	input logic       clk,
	input logic       arst_n,
	input logic       valid,
	input logic       ready,
	input logic [7:0] data,
	input logic       push,
	input logic       full,
	input logic       pop,
	input logic       empty
);

	// ==================================================
	// Output bus
	// ==================================================
	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		valid && !ready |=> valid && $stable(data))
		else $error("output byte changed while stalled");

	a_data_known: assert property (@(posedge clk) disable iff (!arst_n)
		valid |-> !$isunknown(data))
		else $error("unknown output byte while valid");

	// Queue handshakes
	a_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
		else $error("push issued while full");

	a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
		else $error("pop issued while empty");

endmodule

bind out_arbiter timetag_props u_arb_props (
	.clk    (clk),
	.arst_n (arst_n),
	.valid  (out_valid),
	.ready  (out_ready),
	.data   (out_data),
	.push   (1'b0),
	.full   (1'b0),
	.pop    (tags.pop || replies.pop),
	.empty  (1'b0)
);

bind rec_fifo timetag_props u_fifo_props (
	.clk    (clk),
	.arst_n (arst_n),
	.valid  (1'b0),
	.ready  (1'b1),
	.data   (8'h00),
	.push   (q.push),
	.full   (q.full),
	.pop    (q.pop),
	.empty  (q.empty)
);

// ==== dv/timetag_tb.sv ====
`include "timetag_params.svh"

module timetag_tb;

	localparam int TIMEOUT = 5000;

	logic                    clk;
	logic                    arst_n;
	logic [7:0]              cmd_data;
	logic                    cmd_wr;
	logic [`TT_CHANNELS-1:0] strobe_in;
	logic [7:0]              out_data;
	logic                    out_valid;
	logic                    out_ready;

	// Model state
	timetag_pkg::cfg_t       cfg_model;
	logic [3:0]              strobe_lvl;
	logic                    ovf_next;
	logic                    hold_ready;
	logic [31:0]             cyc = '0;
	logic                    ref_set = 1'b0;
	logic [`TT_TS_BITS-1:0]  ref_ts;
	logic [`TT_TS_BITS-1:0]  ref_cyc;
	timetag_pkg::tag_rec_t   exp_tags[$];  // ts holds the drive cycle
	timetag_pkg::reply_rec_t exp_replies[$];

	// Collector state
	timetag_pkg::tag_rec_t   tag_got[$];
	timetag_pkg::reply_rec_t reply_got[$];
	timetag_pkg::tag_rec_t   got_tag;
	timetag_pkg::reply_rec_t got_reply;
	logic [7:0]              rec_bytes[$];
	logic                    stall_q = 1'b0;
	logic [7:0]              stall_byte;
	int                      n_kept;

	timetag_top dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_data  (cmd_data),
		.cmd_wr    (cmd_wr),
		.strobe_in (strobe_in),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// ==================================================
	// Checks and helpers
	// ==================================================
	task automatic abort_run(input string why);
		if (why != "")
			$display("ERROR at time %0t: %s", $time, why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
			abort_run("");
		end
	endtask

	task automatic compare_tag(input string name, input timetag_pkg::tag_rec_t got,
			input timetag_pkg::tag_rec_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
			abort_run("");
		end
	endtask

	task automatic compare_reply(input string name, input timetag_pkg::reply_rec_t got,
			input timetag_pkg::reply_rec_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
			abort_run("");
		end
	endtask

	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Polarity 0 fires when the line goes high, 1 when it goes low
	function automatic logic [3:0] expect_hits(input logic [3:0] old_lvl, input logic [3:0] new_lvl,
			input timetag_pkg::cfg_t c);
		logic [3:0] rise;
		logic [3:0] fall;
		rise = ~old_lvl & new_lvl;
		fall = old_lvl & ~new_lvl;
		return ((rise & ~c.polarity) | (fall & c.polarity)) & c.enable;
	endfunction

	task automatic send_byte(input logic [7:0] b);
		cmd_data = b;
		cmd_wr   = 1'b1;
		tick(1);
		cmd_wr   = 1'b0;
		tick($urandom % 3);
	endtask

	task automatic send_frame(input logic [7:0] addr, input logic [7:0] data);
		timetag_pkg::reply_rec_t r;
		r.err  = !(addr == `TT_ADDR_ENABLE || addr == `TT_ADDR_POLARITY);
		r.addr = addr;
		r.data = data;
		exp_replies.push_back(r);
		send_byte(`TT_SYNC_BYTE);
		send_byte(addr);
		send_byte(data);
		if (addr == `TT_ADDR_ENABLE)
			cfg_model.enable = data[3:0];
		if (addr == `TT_ADDR_POLARITY)
			cfg_model.polarity = data[3:0];
	endtask

	task automatic check_replies();
		int t = 0;
		while (reply_got.size() < exp_replies.size()) begin
			tick(1);
			t++;
			if (t > TIMEOUT)
				abort_run("timeout waiting for a reply record");
		end
		tick(20);
		if (reply_got.size() != exp_replies.size())
			abort_run("more reply records than frames sent");
		foreach (exp_replies[i])
			compare_reply("reply record", reply_got[i], exp_replies[i]);
		reply_got.delete();
		exp_replies.delete();
	endtask

	task automatic strobe_step(input logic [3:0] nxt);
		timetag_pkg::tag_rec_t e;
		e.hit      = expect_hits(strobe_lvl, nxt, cfg_model);
		e.overflow = ovf_next;
		e.ts       = cyc[`TT_TS_BITS-1:0];
		if (e.hit != '0) begin
			exp_tags.push_back(e);
			ovf_next = 1'b0;
		end
		strobe_in  = nxt;
		strobe_lvl = nxt;
	endtask

	task automatic strobe_burst(input int steps);
		repeat (steps) begin
			strobe_step(4'($urandom));
			tick(1 + $urandom % 4);
		end
	endtask

	// Timestamps must differ exactly as the drive cycles do
	task automatic compare_tags(input int n);
		timetag_pkg::tag_rec_t e;
		for (int i = 0; i < n; i++) begin
			e = exp_tags[i];
			if (!ref_set) begin
				ref_ts  = tag_got[i].ts;
				ref_cyc = e.ts;
				ref_set = 1'b1;
			end
			e.ts = ref_ts + (exp_tags[i].ts - ref_cyc);
			compare_tag("tag record", tag_got[i], e);
		end
	endtask

	task automatic wait_tags(input int n);
		int t = 0;
		while (tag_got.size() < n) begin
			tick(1);
			t++;
			if (t > TIMEOUT)
				abort_run("timeout waiting for tag records");
		end
	endtask

	task automatic drain_tags();
		wait_tags(exp_tags.size());
		tick(40);
		if (tag_got.size() != exp_tags.size())
			abort_run("tag records appeared without a matching strobe edge");
		compare_tags(exp_tags.size());
		tag_got.delete();
		exp_tags.delete();
	endtask

	// ==================================================
	// Output collector
	// ==================================================
	always @(posedge clk) begin
		if (arst_n) begin
			if (stall_q) begin
				compare_byte("out_valid", {7'b0, out_valid}, 8'h01);
				compare_byte("out_data", out_data, stall_byte);
			end
			stall_q    = out_valid && !out_ready;
			stall_byte = out_data;
			if (out_valid && out_ready) begin
				rec_bytes.push_back(out_data);
				if (rec_bytes.size() == (rec_bytes[0][7] ? 3 : 4)) begin
					if (rec_bytes[0][7]) begin
						compare_byte("out_data", rec_bytes[0] & 8'h3F, 8'h00);
						got_reply.err  = rec_bytes[0][6];
						got_reply.addr = rec_bytes[1];
						got_reply.data = rec_bytes[2];
						reply_got.push_back(got_reply);
					end else begin
						compare_byte("out_data", rec_bytes[0] & 8'h30, 8'h00);
						got_tag.overflow = rec_bytes[0][6];
						got_tag.hit      = rec_bytes[0][3:0];
						got_tag.ts       = {rec_bytes[1], rec_bytes[2], rec_bytes[3]};
						tag_got.push_back(got_tag);
					end
					rec_bytes.delete();
				end
			end
		end
	end

	// Host back-pressure
	always @(posedge clk) begin
		#1;
		out_ready = hold_ready ? 1'b0 : (($urandom % 4) != 0);
	end

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		void'($urandom(32'hcf63_3841));
		arst_n     = 1'b0;
		cmd_data   = '0;
		cmd_wr     = 1'b0;
		strobe_in  = '0;
		out_ready  = 1'b0;
		hold_ready = 1'b0;
		cfg_model  = '0;
		strobe_lvl = '0;
		ovf_next   = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		tick(4);

		// Garbage ahead of the first sync byte
		repeat (6) send_byte(8'h10 | 8'($urandom % 8'h90));
		tick(50);
		if (reply_got.size() != 0)
			abort_run("reply produced from garbage bytes");
		send_frame(8'h05, 8'($urandom));
		check_replies();
		send_frame(`TT_ADDR_ENABLE, 8'h00);
		check_replies();

		strobe_burst(12); // Nothing enabled yet
		drain_tags();
		send_frame(`TT_ADDR_ENABLE, 8'h03 | {4'($urandom), 4'h0});
		check_replies();
		strobe_burst(12);
		drain_tags();

		send_frame(`TT_ADDR_ENABLE, 8'h0F);
		check_replies();
		strobe_burst(12);
		drain_tags();

		// Falling edges, then mixed polarity
		send_frame(`TT_ADDR_POLARITY, 8'h0F);
		check_replies();
		strobe_burst(12);
		drain_tags();
		send_frame(`TT_ADDR_POLARITY, 8'h05);
		check_replies();
		strobe_burst(12);
		drain_tags();

		// ==================================================
		// Overflow with the host stalled
		// ==================================================
		send_frame(`TT_ADDR_POLARITY, 8'h00);
		check_replies();
		strobe_step(4'h0);
		tick(4);
		hold_ready = 1'b1;
		tick(4);
		for (int i = 0; i < 48; i++) begin
			strobe_step((i % 2 == 0) ? 4'hF : 4'h0);
			tick(2);
		end
		tick(20);
		hold_ready = 1'b0;
		wait_tags(16);
		tick(100);
		n_kept = tag_got.size();
		if (n_kept >= exp_tags.size())
			abort_run("no tag record was dropped while the queue was full");
		compare_tags(n_kept);
		tag_got.delete();
		exp_tags.delete();
		ovf_next = 1'b1; // Next record reports the loss
		strobe_step(4'hF);
		tick(3);
		strobe_step(4'h0);
		tick(3);
		strobe_step(4'hF);
		tick(3);
		drain_tags();

		// Replies and tags sharing the bus
		fork
			strobe_burst(12);
			begin
				tick(5);
				send_frame(8'h3C, 8'($urandom));
			end
		join
		check_replies();
		drain_tags();

		tick(20);
		if (tag_got.size() == 0 && reply_got.size() == 0 && rec_bytes.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_run("records left over at the end of the run");
		end
	end

endmodule

// ==== sim.f ====
+incdir+logic
logic/timetag_pkg.sv
logic/rec_fifo_if.sv
logic/cmd_decoder.sv
logic/strobe_tagger.sv
logic/rec_fifo.sv
logic/out_arbiter.sv
logic/timetag_top.sv
dv/timetag_props.sv
dv/timetag_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module timetag_tb -o timetag_sim

out=$(./obj_dir/timetag_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^Test completed successfully$"; then
	exit 0
fi
exit 1
